// File: tests/execute_trace.txt
# in:  test valid ptk pause flush pmem busy op1 sel1 pc1 a1 b1 imm1 exc1 pa1 op2 sel2 pc2 a2 b2 imm2 pa2
# exp: ren wstrb addr wdata pex bfl btgt xfl bisb btk fwen fd1 fd2 rval rwen res1 res2 addr1 exc1
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 4 0 0 0 0 0 0 0 0 0 0 0 0
2 3 0 0 0 0 0 0 1 100 5 7 0 0 0 9 3 104 80000000 4 0 0
0 0 80000000 0 0 0 108 0 0 0 3 c f8000000 3 3 c f8000000 5 0
2 3 2 0 0 0 0 5 1 1fc ffffffff 1 0 0 0 e 4 200 0 0 40 240
0 0 40 0 0 0 240 0 2 2 3 1 204 3 3 1 204 ffffffff 0
3 3 0 0 0 0 0 a 4 300 9 9 20 0 0 0 1 304 1 1 0 0
0 0 1 0 0 1 320 0 1 1 3 0 2 1 1 0 0 29 0
3 3 1 0 0 0 0 b 4 400 1 2 10 0 410 c 4 500 5 3 8 0
0 0 d 0 0 0 504 0 3 1 3 0 0 3 3 0 0 11 0
4 3 0 0 0 0 0 0 1 0 2 3 0 0 0 12 5 0 1000 abcd 3 0
0 8 1003 cd000000 0 0 4 0 0 0 3 5 0 3 3 5 0 2 0
4 3 0 0 0 0 0 f 5 0 2000 0 4 0 0 11 5 0 3000 1234 0 0
1 0 2004 0 0 0 4 0 0 0 3 0 0 3 3 0 0 2004 0
4 1 0 0 0 0 0 11 5 0 3000 55 2 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 4 0 0 0 0 0 0 1 0 0 0 3002 9
4 1 0 0 0 0 0 f 5 0 0 0 0 3 0 0 0 0 0 0 0 0
0 0 0 0 0 0 4 1 0 0 0 0 0 1 0 0 0 0 3
5 3 0 0 0 0 1 f 5 0 100 0 0 0 0 0 1 0 4 4 0 0
0 0 0 0 1 0 4 0 0 0 3 0 8 0 0 0 0 0 0
5 3 0 0 0 0 0 0 1 0 10 1 0 0 0 0 1 0 20 2 0 0
0 0 20 0 0 0 4 0 0 0 3 11 22 3 3 11 22 10 0
5 3 0 1 0 1 1 f 5 0 40 0 0 0 0 0 1 0 7 7 0 0
0 0 0 0 1 0 4 0 0 0 3 0 e 3 3 11 22 10 0
6 3 0 1 1 1 1 f 5 0 40 0 0 0 0 0 1 0 7 7 0 0
0 0 0 0 1 0 4 0 0 0 3 0 e 0 0 0 0 0 0

// File: execute_stage.f
+incdir+common
common/exe_pkg.sv
execute/exe_lane.sv
execute/exe_ctrl.sv
execute/exe_mem_reg.sv
src/execute_stage.sv
tests/tb_execute_stage.sv

// File: run_sim.sh
#!/bin/bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f execute_stage.f --top-module tb_execute_stage -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: tests/tb_execute_stage.sv
`default_nettype none

`include "exe_params.svh"

module tb_execute_stage;

    localparam int MAX_REC    = 64;
    localparam int RST_CYCLES = 16;
    localparam int N_IN       = 22;
    localparam int N_EXP      = 19;

    logic                     clk;
    logic                     arst_n_i;
    logic [`EXE_XLEN-1:0]     pc1, pc2, a1, b1, a2, b2, imm1, imm2, pa1, pa2;
    exe_pkg::alu_op_t         aluop1, aluop2;
    exe_pkg::alu_sel_t        alusel1, alusel2;
    logic [`EXE_REG_AW-1:0]   rd1, rd2;
    logic                     we1, we2;
    exe_pkg::exc_code_t       exc1, exc2;
    logic [`EXE_LANES-1:0]    pred_taken, valid;
    logic                     pause, flush, pause_mem, dcache_busy;

    logic                     dc_ren, pause_ex, br_flush, ex_flush;
    logic [`EXE_WSTRB_W-1:0]  dc_wstrb;
    logic [`EXE_XLEN-1:0]     dc_addr, dc_wdata, br_target, bpu_tgt1, bpu_tgt2;
    logic [`EXE_LANES-1:0]    bpu_isb, bpu_tk, fwd_wen, m_valid, m_wen;
    logic [`EXE_REG_AW-1:0]   fwd_rd1, fwd_rd2, m_rd1, m_rd2;
    logic [`EXE_XLEN-1:0]     fwd_d1, fwd_d2, m_res1, m_res2, m_addr1, m_addr2;
    exe_pkg::exc_code_t       m_exc1, m_exc2;

    // register fields that have no trace column
    logic [`EXE_REG_AW-1:0]   exp_rd1, exp_rd2;
    logic [`EXE_XLEN-1:0]     exp_addr2;
    exe_pkg::exc_code_t       exp_exc2;

    logic [31:0] in_f  [0:MAX_REC-1][0:N_IN-1];   // one cycle of stimulus
    logic [31:0] exp_f [0:MAX_REC-1][0:N_EXP-1];  // its expected outputs
    int          n_rec;
    bit          loaded;
    int          errors;
    int          checks;
    int          test_errs;
    int          n_tests;
    int          cur_test;

    execute_stage u_dut (
        .clk(clk), .arst_n_i(arst_n_i),
        .pc1_i(pc1), .aluop1_i(aluop1), .alusel1_i(alusel1), .rs1_a_i(a1), .rs1_b_i(b1),
        .imm1_i(imm1), .rd1_i(rd1), .we1_i(we1), .exc1_i(exc1), .pred_addr1_i(pa1),
        .pc2_i(pc2), .aluop2_i(aluop2), .alusel2_i(alusel2), .rs2_a_i(a2), .rs2_b_i(b2),
        .imm2_i(imm2), .rd2_i(rd2), .we2_i(we2), .exc2_i(exc2), .pred_addr2_i(pa2),
        .pred_taken_i(pred_taken), .valid_i(valid), .pause_i(pause), .flush_i(flush),
        .pause_mem_i(pause_mem), .dcache_busy_i(dcache_busy),
        .dcache_ren_o(dc_ren), .dcache_wstrb_o(dc_wstrb), .dcache_addr_o(dc_addr),
        .dcache_wdata_o(dc_wdata), .pause_ex_o(pause_ex), .branch_flush_o(br_flush),
        .branch_target_o(br_target), .excp_flush_o(ex_flush),
        .bpu_is_branch_o(bpu_isb), .bpu_taken_o(bpu_tk), .bpu_target1_o(bpu_tgt1),
        .bpu_target2_o(bpu_tgt2), .fwd_wen_o(fwd_wen), .fwd_rd1_o(fwd_rd1),
        .fwd_rd2_o(fwd_rd2), .fwd_data1_o(fwd_d1), .fwd_data2_o(fwd_d2),
        .mem_valid_o(m_valid), .mem_wen_o(m_wen), .mem_rd1_o(m_rd1), .mem_rd2_o(m_rd2),
        .mem_result1_o(m_res1), .mem_result2_o(m_res2), .mem_addr1_o(m_addr1),
        .mem_addr2_o(m_addr2), .mem_exc1_o(m_exc1), .mem_exc2_o(m_exc2)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // budget is four times the nominal run
    initial
    begin
        wait (loaded);
        #((n_rec + RST_CYCLES) * 8 * 4);
        $display("timeout: the trace did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
        checks++;
        assert (got === expv)
        else
        begin
            $display("[ERROR] test %0d %s: got 0x%h, expected 0x%h", cur_test, name, got, expv);
            errors++;
            test_errs++;
        end
    endtask

    // next pc of a resolved branch
    function automatic logic [31:0] branch_dest(input logic [31:0] pc,
                                                input logic [31:0] imm,
                                                input logic        tk);
        return tk ? pc + imm : pc + 32'd4;
    endfunction

    task automatic read_trace();
        int    fd;
        int    cnt;
        int    code;
        bit    want_in;
        string line;
        fd      = $fopen("tests/execute_trace.txt", "r");
        want_in = 1'b1;
        n_rec   = 0;
        if (fd == 0)
        begin
            $display("could not open the trace file");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && n_rec < MAX_REC)
            begin
                code = $fgets(line, fd);
                if (code != 0 && line.len() > 1 && line.getc(0) != 8'h23)
                begin
                    if (want_in)
                        cnt = $sscanf(line,
                            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            in_f[n_rec][0], in_f[n_rec][1], in_f[n_rec][2], in_f[n_rec][3],
                            in_f[n_rec][4], in_f[n_rec][5], in_f[n_rec][6], in_f[n_rec][7],
                            in_f[n_rec][8], in_f[n_rec][9], in_f[n_rec][10], in_f[n_rec][11],
                            in_f[n_rec][12], in_f[n_rec][13], in_f[n_rec][14],
                            in_f[n_rec][15], in_f[n_rec][16], in_f[n_rec][17],
                            in_f[n_rec][18], in_f[n_rec][19], in_f[n_rec][20],
                            in_f[n_rec][21]);
                    else
                        cnt = $sscanf(line,
                            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            exp_f[n_rec][0], exp_f[n_rec][1], exp_f[n_rec][2],
                            exp_f[n_rec][3], exp_f[n_rec][4], exp_f[n_rec][5],
                            exp_f[n_rec][6], exp_f[n_rec][7], exp_f[n_rec][8],
                            exp_f[n_rec][9], exp_f[n_rec][10], exp_f[n_rec][11],
                            exp_f[n_rec][12], exp_f[n_rec][13], exp_f[n_rec][14],
                            exp_f[n_rec][15], exp_f[n_rec][16], exp_f[n_rec][17],
                            exp_f[n_rec][18]);
                    if (cnt != (want_in ? N_IN : N_EXP))
                    begin
                        $display("malformed trace line: %s", line);
                        errors++;
                    end
                    if (!want_in)
                        n_rec++;
                    want_in = !want_in;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_rec(input int i);
        valid       = in_f[i][1][1:0];
        pred_taken  = in_f[i][2][1:0];
        pause       = in_f[i][3][0];
        flush       = in_f[i][4][0];
        pause_mem   = in_f[i][5][0];
        dcache_busy = in_f[i][6][0];
        aluop1      = exe_pkg::alu_op_t'(in_f[i][7][4:0]);
        alusel1     = exe_pkg::alu_sel_t'(in_f[i][8][2:0]);
        pc1         = in_f[i][9];
        a1          = in_f[i][10];
        b1          = in_f[i][11];
        imm1        = in_f[i][12];
        exc1        = in_f[i][13][`EXE_EXC_W-1:0];
        pa1         = in_f[i][14];
        aluop2      = exe_pkg::alu_op_t'(in_f[i][15][4:0]);
        alusel2     = exe_pkg::alu_sel_t'(in_f[i][16][2:0]);
        pc2         = in_f[i][17];
        a2          = in_f[i][18];
        b2          = in_f[i][19];
        imm2        = in_f[i][20];
        pa2         = in_f[i][21];
    endtask

    task automatic check_reset_state();
        check_val("mem_valid_o", 32'(m_valid), 32'h0);
        check_val("mem_wen_o", 32'(m_wen), 32'h0);
        check_val("mem_rd1_o", 32'(m_rd1), 32'h0);
        check_val("mem_rd2_o", 32'(m_rd2), 32'h0);
        check_val("mem_result1_o", m_res1, 32'h0);
        check_val("mem_result2_o", m_res2, 32'h0);
        check_val("mem_addr1_o", m_addr1, 32'h0);
        check_val("mem_addr2_o", m_addr2, 32'h0);
        check_val("mem_exc1_o", 32'(m_exc1), 32'h0);
        check_val("mem_exc2_o", 32'(m_exc2), 32'h0);
        check_val("branch_flush_o", 32'(br_flush), 32'h0);
        check_val("excp_flush_o", 32'(ex_flush), 32'h0);
        check_val("dcache_ren_o", 32'(dc_ren), 32'h0);
        check_val("dcache_wstrb_o", 32'(dc_wstrb), 32'h0);
    endtask

    task automatic check_comb(input int i);
        check_val("dcache_ren_o", 32'(dc_ren), exp_f[i][0]);
        check_val("dcache_wstrb_o", 32'(dc_wstrb), exp_f[i][1]);
        check_val("dcache_addr_o", dc_addr, exp_f[i][2]);
        check_val("dcache_wdata_o", dc_wdata, exp_f[i][3]);
        check_val("pause_ex_o", 32'(pause_ex), exp_f[i][4]);
        check_val("branch_flush_o", 32'(br_flush), exp_f[i][5]);
        check_val("branch_target_o", br_target, exp_f[i][6]);
        check_val("excp_flush_o", 32'(ex_flush), exp_f[i][7]);
        check_val("bpu_is_branch_o", 32'(bpu_isb), exp_f[i][8]);
        check_val("bpu_taken_o", 32'(bpu_tk), exp_f[i][9]);
        check_val("fwd_wen_o", 32'(fwd_wen), exp_f[i][10]);
        check_val("fwd_data1_o", fwd_d1, exp_f[i][11]);
        check_val("fwd_data2_o", fwd_d2, exp_f[i][12]);
        check_val("fwd_rd1_o", 32'(fwd_rd1), 32'(rd1));
        check_val("fwd_rd2_o", 32'(fwd_rd2), 32'(rd2));
        if (exp_f[i][8][0])
            check_val("bpu_target1_o", bpu_tgt1, branch_dest(pc1, imm1, exp_f[i][9][0]));
        if (exp_f[i][8][1])
            check_val("bpu_target2_o", bpu_tgt2, branch_dest(pc2, imm2, exp_f[i][9][1]));
    endtask

    // next state of the fields the trace leaves out
    task automatic predict_regs(input int i);
        logic                 clr;
        logic                 sq;
        logic [`EXE_XLEN-1:0] addr;
        clr  = flush || (exp_f[i][4][0] && !pause_mem);
        sq   = exp_f[i][8][0] && ((exp_f[i][9][0] != pred_taken[0]) ||
               (exp_f[i][9][0] && (branch_dest(pc1, imm1, 1'b1) != pa1)));
        addr = a2 + imm2;
        if (clr)
        begin
            exp_rd1   = '0;
            exp_rd2   = '0;
            exp_addr2 = '0;
            exp_exc2  = '0;
        end
        else if (!pause)
        begin
            exp_rd1   = rd1;
            exp_rd2   = sq ? '0 : rd2;
            exp_addr2 = sq ? '0 : addr;
            if (sq || !valid[1])
                exp_exc2 = '0;
            else if (exc2 != '0)
                exp_exc2 = exc2;
            else if (alusel2 == exe_pkg::SEL_MEM && addr[1:0] != 2'b00 &&
                     (aluop2 == exe_pkg::OP_LW || aluop2 == exe_pkg::OP_SW))
                exp_exc2 = `EXE_EXC_ALE;
            else
                exp_exc2 = '0;
        end
    endtask

    task automatic check_regs(input int i);
        check_val("mem_valid_o", 32'(m_valid), exp_f[i][13]);
        check_val("mem_wen_o", 32'(m_wen), exp_f[i][14]);
        check_val("mem_result1_o", m_res1, exp_f[i][15]);
        check_val("mem_result2_o", m_res2, exp_f[i][16]);
        check_val("mem_addr1_o", m_addr1, exp_f[i][17]);
        check_val("mem_exc1_o", 32'(m_exc1), exp_f[i][18]);
        check_val("mem_rd1_o", 32'(m_rd1), 32'(exp_rd1));
        check_val("mem_rd2_o", 32'(m_rd2), 32'(exp_rd2));
        check_val("mem_addr2_o", m_addr2, exp_addr2);
        check_val("mem_exc2_o", 32'(m_exc2), 32'(exp_exc2));
    endtask

    task automatic report_test();
        $display("test %0d done with %0d errors", cur_test, test_errs);
        n_tests++;
        test_errs = 0;
    endtask

    initial
    begin
        arst_n_i    = 1'b0;
        valid       = '0;
        pred_taken  = '0;
        pause       = 1'b0;
        flush       = 1'b0;
        pause_mem   = 1'b0;
        dcache_busy = 1'b0;
        aluop1      = exe_pkg::OP_ADD;
        aluop2      = exe_pkg::OP_ADD;
        alusel1     = exe_pkg::SEL_NONE;
        alusel2     = exe_pkg::SEL_NONE;
        {pc1, pc2, a1, b1, a2, b2, imm1, imm2, pa1, pa2} = '0;
        rd1         = 5'd1;   // fixed write-back targets
        rd2         = 5'd2;
        we1         = 1'b1;
        we2         = 1'b1;
        exc1        = '0;
        exc2        = '0;
        exp_rd1     = '0;
        exp_rd2     = '0;
        exp_addr2   = '0;
        exp_exc2    = '0;
        errors      = 0;
        checks      = 0;
        test_errs   = 0;
        n_tests     = 0;
        read_trace();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        cur_test = (n_rec > 0) ? int'(in_f[0][0]) : 0;
        check_reset_state();
        arst_n_i = 1'b1;
        for (int i = 0; i < n_rec; i++)
        begin
            if (int'(in_f[i][0]) != cur_test)
            begin
                report_test();
                cur_test = int'(in_f[i][0]);
            end
            drive_rec(i);
            #3;
            check_comb(i);
            predict_regs(i);
            @(posedge clk);
            #1;
            check_regs(i);
            @(negedge clk);
        end
        report_test();
        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
        if (errors == 0 && n_rec > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`default_nettype none

`include "exe_params.svh"

module execute_stage (
    input  wire logic                    clk,
    input  wire logic                    arst_n_i,
    input  wire logic [`EXE_XLEN-1:0]    pc1_i,
    input  exe_pkg::alu_op_t             aluop1_i,
    input  exe_pkg::alu_sel_t            alusel1_i,
    input  wire logic [`EXE_XLEN-1:0]    rs1_a_i,
    input  wire logic [`EXE_XLEN-1:0]    rs1_b_i,
    input  wire logic [`EXE_XLEN-1:0]    imm1_i,
    input  wire logic [`EXE_REG_AW-1:0]  rd1_i,
    input  wire logic                    we1_i,
    input  exe_pkg::exc_code_t           exc1_i,
    input  wire logic [`EXE_XLEN-1:0]    pred_addr1_i,
    input  wire logic [`EXE_XLEN-1:0]    pc2_i,
    input  exe_pkg::alu_op_t             aluop2_i,
    input  exe_pkg::alu_sel_t            alusel2_i,
    input  wire logic [`EXE_XLEN-1:0]    rs2_a_i,
    input  wire logic [`EXE_XLEN-1:0]    rs2_b_i,
    input  wire logic [`EXE_XLEN-1:0]    imm2_i,
    input  wire logic [`EXE_REG_AW-1:0]  rd2_i,
    input  wire logic                    we2_i,
    input  exe_pkg::exc_code_t           exc2_i,
    input  wire logic [`EXE_XLEN-1:0]    pred_addr2_i,
    input  wire logic [`EXE_LANES-1:0]   pred_taken_i,
    input  wire logic [`EXE_LANES-1:0]   valid_i,
    input  wire logic                    pause_i,
    input  wire logic                    flush_i,
    input  wire logic                    pause_mem_i,
    input  wire logic                    dcache_busy_i,
    output logic                         dcache_ren_o,
    output logic      [`EXE_WSTRB_W-1:0] dcache_wstrb_o,
    output logic      [`EXE_XLEN-1:0]    dcache_addr_o,
    output logic      [`EXE_XLEN-1:0]    dcache_wdata_o,
    output logic                         pause_ex_o,
    output logic                         branch_flush_o,
    output logic      [`EXE_XLEN-1:0]    branch_target_o,
    output logic                         excp_flush_o,
    output logic      [`EXE_LANES-1:0]   bpu_is_branch_o,
    output logic      [`EXE_LANES-1:0]   bpu_taken_o,
    output logic      [`EXE_XLEN-1:0]    bpu_target1_o,
    output logic      [`EXE_XLEN-1:0]    bpu_target2_o,
    output logic      [`EXE_LANES-1:0]   fwd_wen_o,
    output logic      [`EXE_REG_AW-1:0]  fwd_rd1_o,
    output logic      [`EXE_REG_AW-1:0]  fwd_rd2_o,
    output logic      [`EXE_XLEN-1:0]    fwd_data1_o,
    output logic      [`EXE_XLEN-1:0]    fwd_data2_o,
    output logic      [`EXE_LANES-1:0]   mem_valid_o,
    output logic      [`EXE_LANES-1:0]   mem_wen_o,
    output logic      [`EXE_REG_AW-1:0]  mem_rd1_o,
    output logic      [`EXE_REG_AW-1:0]  mem_rd2_o,
    output logic      [`EXE_XLEN-1:0]    mem_result1_o,
    output logic      [`EXE_XLEN-1:0]    mem_result2_o,
    output logic      [`EXE_XLEN-1:0]    mem_addr1_o,
    output logic      [`EXE_XLEN-1:0]    mem_addr2_o,
    output exe_pkg::exc_code_t           mem_exc1_o,
    output exe_pkg::exc_code_t           mem_exc2_o
);

    logic [`EXE_LANES-1:0]   ren;
    logic [`EXE_LANES-1:0]   is_branch;
    logic [`EXE_LANES-1:0]   taken;
    logic [`EXE_LANES-1:0]   mispredict;
    logic [`EXE_WSTRB_W-1:0] wstrb1;
    logic [`EXE_WSTRB_W-1:0] wstrb2;
    logic [`EXE_XLEN-1:0]    addr1;
    logic [`EXE_XLEN-1:0]    addr2;
    logic [`EXE_XLEN-1:0]    wdata1;
    logic [`EXE_XLEN-1:0]    wdata2;
    logic [`EXE_XLEN-1:0]    target1;
    logic [`EXE_XLEN-1:0]    target2;
    exe_pkg::exc_code_t      exc1;
    exe_pkg::exc_code_t      exc2;
    logic                    squash;
    logic                    bubble;

    // forwarding straight from this cycle's lanes
    assign fwd_rd1_o = rd1_i;
    assign fwd_rd2_o = rd2_i;

    exe_lane u_lane1 (
        .valid_i(valid_i[0]), .pc_i(pc1_i), .src_a_i(rs1_a_i), .src_b_i(rs1_b_i),
        .imm_i(imm1_i), .aluop_i(aluop1_i), .alusel_i(alusel1_i), .rd_i(rd1_i),
        .we_i(we1_i), .pred_taken_i(pred_taken_i[0]), .pred_addr_i(pred_addr1_i),
        .exc_i(exc1_i), .result_o(fwd_data1_o), .mem_addr_o(addr1), .mem_wdata_o(wdata1),
        .target_o(target1), .wb_en_o(fwd_wen_o[0]), .mem_ren_o(ren[0]),
        .is_branch_o(is_branch[0]), .taken_o(taken[0]), .mispredict_o(mispredict[0]),
        .mem_wstrb_o(wstrb1), .exc_o(exc1)
    );

    exe_lane u_lane2 (
        .valid_i(valid_i[1]), .pc_i(pc2_i), .src_a_i(rs2_a_i), .src_b_i(rs2_b_i),
        .imm_i(imm2_i), .aluop_i(aluop2_i), .alusel_i(alusel2_i), .rd_i(rd2_i),
        .we_i(we2_i), .pred_taken_i(pred_taken_i[1]), .pred_addr_i(pred_addr2_i),
        .exc_i(exc2_i), .result_o(fwd_data2_o), .mem_addr_o(addr2), .mem_wdata_o(wdata2),
        .target_o(target2), .wb_en_o(fwd_wen_o[1]), .mem_ren_o(ren[1]),
        .is_branch_o(is_branch[1]), .taken_o(taken[1]), .mispredict_o(mispredict[1]),
        .mem_wstrb_o(wstrb2), .exc_o(exc2)
    );

    exe_ctrl u_ctrl (
        .valid_i(valid_i), .ren_i(ren), .wstrb1_i(wstrb1), .wstrb2_i(wstrb2),
        .addr1_i(addr1), .addr2_i(addr2), .wdata1_i(wdata1), .wdata2_i(wdata2),
        .mispredict_i(mispredict), .is_branch_i(is_branch), .taken_i(taken),
        .target1_i(target1), .target2_i(target2), .dcache_busy_i(dcache_busy_i),
        .pause_mem_i(pause_mem_i), .mem_exc1_i(mem_exc1_o), .mem_exc2_i(mem_exc2_o),
        .dcache_ren_o(dcache_ren_o), .dcache_wstrb_o(dcache_wstrb_o),
        .dcache_addr_o(dcache_addr_o), .dcache_wdata_o(dcache_wdata_o),
        .pause_ex_o(pause_ex_o), .branch_flush_o(branch_flush_o),
        .branch_target_o(branch_target_o), .excp_flush_o(excp_flush_o),
        .squash_o(squash), .bubble_o(bubble), .bpu_is_branch_o(bpu_is_branch_o),
        .bpu_taken_o(bpu_taken_o), .bpu_target1_o(bpu_target1_o),
        .bpu_target2_o(bpu_target2_o)
    );

    exe_mem_reg u_mem_reg (
        .clk(clk), .arst_n_i(arst_n_i), .flush_i(flush_i), .pause_i(pause_i),
        .bubble_i(bubble), .squash_i(squash), .valid_i(valid_i),
        .result1_i(fwd_data1_o), .result2_i(fwd_data2_o), .rd1_i(rd1_i), .rd2_i(rd2_i),
        .wen_i(fwd_wen_o), .addr1_i(addr1), .addr2_i(addr2), .exc1_i(exc1), .exc2_i(exc2),
        .mem_valid_o(mem_valid_o), .mem_wen_o(mem_wen_o), .mem_rd1_o(mem_rd1_o),
        .mem_rd2_o(mem_rd2_o), .mem_result1_o(mem_result1_o),
        .mem_result2_o(mem_result2_o), .mem_addr1_o(mem_addr1_o),
        .mem_addr2_o(mem_addr2_o), .mem_exc1_o(mem_exc1_o), .mem_exc2_o(mem_exc2_o)
    );

endmodule

`default_nettype wire

// File: execute/exe_mem_reg.sv
`default_nettype none

`include "exe_params.svh"

module exe_mem_reg (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire logic                   flush_i,
    input  wire logic                   pause_i,
    input  wire logic                   bubble_i,
    input  wire logic                   squash_i,
    input  wire logic [`EXE_LANES-1:0]  valid_i,
    input  wire logic [`EXE_XLEN-1:0]   result1_i,
    input  wire logic [`EXE_XLEN-1:0]   result2_i,
    input  wire logic [`EXE_REG_AW-1:0] rd1_i,
    input  wire logic [`EXE_REG_AW-1:0] rd2_i,
    input  wire logic [`EXE_LANES-1:0]  wen_i,
    input  wire logic [`EXE_XLEN-1:0]   addr1_i,
    input  wire logic [`EXE_XLEN-1:0]   addr2_i,
    input  exe_pkg::exc_code_t          exc1_i,
    input  exe_pkg::exc_code_t          exc2_i,
    output logic      [`EXE_LANES-1:0]  mem_valid_o,
    output logic      [`EXE_LANES-1:0]  mem_wen_o,
    output logic      [`EXE_REG_AW-1:0] mem_rd1_o,
    output logic      [`EXE_REG_AW-1:0] mem_rd2_o,
    output logic      [`EXE_XLEN-1:0]   mem_result1_o,
    output logic      [`EXE_XLEN-1:0]   mem_result2_o,
    output logic      [`EXE_XLEN-1:0]   mem_addr1_o,
    output logic      [`EXE_XLEN-1:0]   mem_addr2_o,
    output exe_pkg::exc_code_t          mem_exc1_o,
    output exe_pkg::exc_code_t          mem_exc2_o
);

    logic clr;
    logic load;
    logic keep1;
    logic keep2;

    // flush beats bubble, bubble beats pause
    assign clr   = flush_i || bubble_i;
    assign load  = clr || !pause_i;
    assign keep1 = !clr;
    assign keep2 = !clr && !squash_i;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            mem_valid_o   <= '0;
            mem_wen_o     <= '0;
            mem_rd1_o     <= '0;
            mem_rd2_o     <= '0;
            mem_result1_o <= '0;
            mem_result2_o <= '0;
            mem_addr1_o   <= '0;
            mem_addr2_o   <= '0;
            mem_exc1_o    <= '0;
            mem_exc2_o    <= '0;
        end
        else if (load)   // otherwise hold for the mem stage
        begin
            mem_valid_o   <= valid_i & {keep2, keep1};
            mem_wen_o     <= wen_i & {keep2, keep1};
            mem_rd1_o     <= keep1 ? rd1_i : '0;
            mem_rd2_o     <= keep2 ? rd2_i : '0;
            mem_result1_o <= keep1 ? result1_i : '0;
            mem_result2_o <= keep2 ? result2_i : '0;
            mem_addr1_o   <= keep1 ? addr1_i : '0;
            mem_addr2_o   <= keep2 ? addr2_i : '0;
            mem_exc1_o    <= keep1 ? exc1_i : '0;
            mem_exc2_o    <= keep2 ? exc2_i : '0;
        end
    end

endmodule

`default_nettype wire

// File: execute/exe_ctrl.sv
`default_nettype none

`include "exe_params.svh"

module exe_ctrl (
    input  wire logic [`EXE_LANES-1:0]   valid_i,
    input  wire logic [`EXE_LANES-1:0]   ren_i,
    input  wire logic [`EXE_WSTRB_W-1:0] wstrb1_i,
    input  wire logic [`EXE_WSTRB_W-1:0] wstrb2_i,
    input  wire logic [`EXE_XLEN-1:0]    addr1_i,
    input  wire logic [`EXE_XLEN-1:0]    addr2_i,
    input  wire logic [`EXE_XLEN-1:0]    wdata1_i,
    input  wire logic [`EXE_XLEN-1:0]    wdata2_i,
    input  wire logic [`EXE_LANES-1:0]   mispredict_i,
    input  wire logic [`EXE_LANES-1:0]   is_branch_i,
    input  wire logic [`EXE_LANES-1:0]   taken_i,
    input  wire logic [`EXE_XLEN-1:0]    target1_i,
    input  wire logic [`EXE_XLEN-1:0]    target2_i,
    input  wire logic                    dcache_busy_i,
    input  wire logic                    pause_mem_i,
    input  exe_pkg::exc_code_t           mem_exc1_i,
    input  exe_pkg::exc_code_t           mem_exc2_i,
    output logic                         dcache_ren_o,
    output logic      [`EXE_WSTRB_W-1:0] dcache_wstrb_o,
    output logic      [`EXE_XLEN-1:0]    dcache_addr_o,
    output logic      [`EXE_XLEN-1:0]    dcache_wdata_o,
    output logic                         pause_ex_o,
    output logic                         branch_flush_o,
    output logic      [`EXE_XLEN-1:0]    branch_target_o,
    output logic                         excp_flush_o,
    output logic                         squash_o,
    output logic                         bubble_o,
    output logic      [`EXE_LANES-1:0]   bpu_is_branch_o,
    output logic      [`EXE_LANES-1:0]   bpu_taken_o,
    output logic      [`EXE_XLEN-1:0]    bpu_target1_o,
    output logic      [`EXE_XLEN-1:0]    bpu_target2_o
);

    logic [`EXE_LANES-1:0] mem_op;
    logic [`EXE_LANES-1:0] mis;
    logic                  sel_lane0;

    assign mem_op[0] = valid_i[0] && (ren_i[0] || (wstrb1_i != '0));
    assign mem_op[1] = valid_i[1] && (ren_i[1] || (wstrb2_i != '0));
    assign sel_lane0 = mem_op[0];   // lane 0 first, in program order

    // nothing goes to the cache while it is busy
    assign dcache_ren_o   = !dcache_busy_i && (sel_lane0 ? ren_i[0] : ren_i[1]);
    assign dcache_wstrb_o = dcache_busy_i ? '0 : (sel_lane0 ? wstrb1_i : wstrb2_i);
    assign dcache_addr_o  = dcache_busy_i ? '0 : (sel_lane0 ? addr1_i : addr2_i);
    assign dcache_wdata_o = dcache_busy_i ? '0 : (sel_lane0 ? wdata1_i : wdata2_i);

    assign pause_ex_o = dcache_busy_i && (|mem_op);

    assign mis             = valid_i & mispredict_i;
    assign branch_flush_o  = (|mis) && !pause_ex_o && !pause_mem_i;
    assign branch_target_o = mis[0] ? target1_i : target2_i;

    // taken from the registered side
    assign excp_flush_o = ((mem_exc1_i != '0) || (mem_exc2_i != '0)) &&
                          !pause_ex_o && !pause_mem_i;

    assign squash_o = mis[0];                       // younger lane is on the wrong path
    assign bubble_o = pause_ex_o && !pause_mem_i;

    assign bpu_is_branch_o = valid_i & is_branch_i;
    assign bpu_taken_o     = valid_i & taken_i;
    assign bpu_target1_o   = target1_i;
    assign bpu_target2_o   = target2_i;

endmodule

`default_nettype wire

// File: execute/exe_lane.sv
`default_nettype none

`include "exe_params.svh"

module exe_lane (
    input  wire logic                      valid_i,
    input  wire logic [`EXE_XLEN-1:0]      pc_i,
    input  wire logic [`EXE_XLEN-1:0]      src_a_i,
    input  wire logic [`EXE_XLEN-1:0]      src_b_i,
    input  wire logic [`EXE_XLEN-1:0]      imm_i,
    input  exe_pkg::alu_op_t               aluop_i,
    input  exe_pkg::alu_sel_t              alusel_i,
    input  wire logic [`EXE_REG_AW-1:0]    rd_i,
    input  wire logic                      we_i,
    input  wire logic                      pred_taken_i,
    input  wire logic [`EXE_XLEN-1:0]      pred_addr_i,
    input  exe_pkg::exc_code_t             exc_i,
    output logic      [`EXE_XLEN-1:0]      result_o,
    output logic      [`EXE_XLEN-1:0]      mem_addr_o,
    output logic      [`EXE_XLEN-1:0]      mem_wdata_o,
    output logic      [`EXE_XLEN-1:0]      target_o,
    output logic                           wb_en_o,
    output logic                           mem_ren_o,
    output logic                           is_branch_o,
    output logic                           taken_o,
    output logic                           mispredict_o,
    output logic      [`EXE_WSTRB_W-1:0]   mem_wstrb_o,
    output exe_pkg::exc_code_t             exc_o
);

    localparam int SHAMT_W = $clog2(`EXE_XLEN);

    logic [`EXE_XLEN-1:0] alu_res;
    logic [`EXE_XLEN-1:0] pc_plus4;
    logic                 cond;
    logic                 is_mem;
    logic                 is_load;
    logic                 is_store;
    logic                 is_word;
    logic                 misaligned;
    logic                 has_exc;

    assign pc_plus4 = pc_i + `EXE_XLEN'd4;

    always_comb
    begin
        case (aluop_i)
            exe_pkg::OP_ADD:  alu_res = src_a_i + src_b_i;
            exe_pkg::OP_SUB:  alu_res = src_a_i - src_b_i;
            exe_pkg::OP_AND:  alu_res = src_a_i & src_b_i;
            exe_pkg::OP_OR:   alu_res = src_a_i | src_b_i;
            exe_pkg::OP_XOR:  alu_res = src_a_i ^ src_b_i;
            exe_pkg::OP_SLT:  alu_res = {{(`EXE_XLEN-1){1'b0}}, $signed(src_a_i) < $signed(src_b_i)};
            exe_pkg::OP_SLTU: alu_res = {{(`EXE_XLEN-1){1'b0}}, src_a_i < src_b_i};
            exe_pkg::OP_SLL:  alu_res = src_a_i << src_b_i[SHAMT_W-1:0];
            exe_pkg::OP_SRL:  alu_res = src_a_i >> src_b_i[SHAMT_W-1:0];
            exe_pkg::OP_SRA:  alu_res = $signed(src_a_i) >>> src_b_i[SHAMT_W-1:0];
            default:          alu_res = '0;
        endcase
    end

    // unit select picks what goes to write-back
    always_comb
    begin
        case (alusel_i)
            exe_pkg::SEL_ARITH,
            exe_pkg::SEL_LOGIC,
            exe_pkg::SEL_SHIFT:  result_o = alu_res;
            exe_pkg::SEL_BRANCH: result_o = (aluop_i == exe_pkg::OP_JAL) ? pc_plus4 : '0;
            default:             result_o = '0;   // loads return data in mem
        endcase
    end

    // branch direction
    always_comb
    begin
        case (aluop_i)
            exe_pkg::OP_BEQ: cond = src_a_i == src_b_i;
            exe_pkg::OP_BNE: cond = src_a_i != src_b_i;
            exe_pkg::OP_BLT: cond = $signed(src_a_i) < $signed(src_b_i);
            exe_pkg::OP_BGE: cond = $signed(src_a_i) >= $signed(src_b_i);
            exe_pkg::OP_JAL: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    assign is_branch_o = valid_i && (alusel_i == exe_pkg::SEL_BRANCH);
    assign taken_o     = is_branch_o && cond;
    assign target_o    = taken_o ? pc_i + imm_i : pc_plus4;   // actual next pc

    // wrong direction, or right direction with a wrong target
    assign mispredict_o = is_branch_o &&
                          ((taken_o != pred_taken_i) ||
                           (taken_o && (target_o != pred_addr_i)));

    assign is_mem   = valid_i && (alusel_i == exe_pkg::SEL_MEM);
    assign is_load  = is_mem && (aluop_i == exe_pkg::OP_LW || aluop_i == exe_pkg::OP_LB);
    assign is_store = is_mem && (aluop_i == exe_pkg::OP_SW || aluop_i == exe_pkg::OP_SB);
    assign is_word  = (aluop_i == exe_pkg::OP_LW) || (aluop_i == exe_pkg::OP_SW);

    assign mem_addr_o = src_a_i + imm_i;
    assign misaligned = is_mem && is_word && (mem_addr_o[1:0] != 2'b00);

    // earlier stage code wins over ale
    always_comb
    begin
        if (!valid_i)
            exc_o = '0;
        else if (exc_i != '0)
            exc_o = exc_i;
        else if (misaligned)
            exc_o = `EXE_EXC_ALE;
        else
            exc_o = '0;
    end

    assign has_exc = exc_o != '0;

    always_comb
    begin
        mem_wstrb_o = '0;
        mem_wdata_o = '0;
        if (is_store && !has_exc)
        begin
            if (is_word)
            begin
                mem_wstrb_o = '1;
                mem_wdata_o = src_b_i;
            end
            else
            begin
                // byte into its lane
                mem_wstrb_o = {{(`EXE_WSTRB_W-1){1'b0}}, 1'b1} << mem_addr_o[1:0];
                mem_wdata_o = {{(`EXE_XLEN-8){1'b0}}, src_b_i[7:0]} << {mem_addr_o[1:0], 3'b000};
            end
        end
    end

    assign mem_ren_o = is_load && !has_exc;
    assign wb_en_o   = valid_i && we_i && (rd_i != '0) && !has_exc;   // r0 never written

endmodule

`default_nettype wire

// File: common/exe_pkg.sv
`default_nettype none

`include "exe_params.svh"

package exe_pkg;

    // 19 operations need 5 bits
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL,
        OP_LW,
        OP_LB,
        OP_SW,
        OP_SB
    } alu_op_t;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_BRANCH,
        SEL_MEM
    } alu_sel_t;

    typedef logic [`EXE_EXC_W-1:0] exc_code_t;

endpackage

`default_nettype wire

// File: common/exe_params.svh
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// datapath widths
`define EXE_XLEN    32
`define EXE_REG_AW  5
`define EXE_LANES   2
`define EXE_WSTRB_W 4

// exception codes, zero is no exception
`define EXE_EXC_W   7
`define EXE_EXC_ALE 7'h09   // address misaligned

`endif
